//--- flist.f
source/bpc_pkg.sv
source/stripe_capture.sv
source/coeff_state_lane.sv
source/top_plane_table.sv
source/bpc_state_gen.sv
verif/bpc_state_gen_asserts.sv
verif/bpc_state_gen_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module bpc_state_gen_tb \
    -f flist.f -o bpc_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/bpc_sim +verilator+error+limit+100 > sim.log 2>&1

grep -qx 'All tests passed!' sim.log \
    && echo "simulation PASS" \
    || { echo "simulation FAIL, see sim.log"; exit 1; }

//--- source/bpc_pkg.sv
package bpc_pkg;

    // stripe column geometry
    localparam int LANES   = 4;
    localparam int COEFF_W = 17;
    localparam int MAG_W   = 16;
    localparam int PLANE_W = 4;

    // planes below this carry no magnitude bit
    localparam int MIN_CODED_PLANE = 4;
    // refinement needs the leading one at least this high
    localparam int GAMMA_MIN_MSB   = 6;
    // stored count to top coded plane
    localparam int TOP_PLANE_OFFSET = 3;

    // subband selector fields
    localparam int LEVEL_W = 3;
    localparam int COMP_W  = 2;
    localparam int BAND_W  = 2;
    localparam int SEL_W   = LEVEL_W + COMP_W + BAND_W;
    localparam int TABLE_DEPTH = 2 ** SEL_W;

    // only the coarsest level owns an LL band
    localparam int TOP_LEVEL = 4;
    // Y, U, V
    localparam int NUM_COMPS = 3;

    // sign-magnitude coefficient, sign on top
    typedef struct packed {
        logic             sign;
        logic [MAG_W-1:0] mag;
    } coeff_t;

    typedef logic [PLANE_W-1:0] plane_t;

    // per-coefficient state for the current plane
    typedef struct packed {
        logic sign;
        logic mag;
        logic gamma;
        logic sigma;
    } lane_state_t;

    // band: 0 ll, 1 hl, 2 lh, 3 hh
    typedef struct packed {
        logic [LEVEL_W-1:0] level;
        logic [COMP_W-1:0]  comp;
        logic [BAND_W-1:0]  band;
    } band_fields_t;

    // decoded fields for validation, flat word as table address
    typedef union packed {
        band_fields_t     f;
        logic [SEL_W-1:0] addr;
    } band_sel_u;

endpackage

//--- source/bpc_state_gen.sv
`timescale 1ns/1ps
module bpc_state_gen (
    input  logic                 clk_rc,
    input  logic                 rst,
    input  logic                 clk_sg,
    input  logic                 stall_vld,
    input  bpc_pkg::coeff_t      coeff_in   [bpc_pkg::LANES],
    input  bpc_pkg::plane_t      bit_plane,
    input  bpc_pkg::band_sel_u   sel,
    input  logic                 cnt_wr_en,
    input  bpc_pkg::band_sel_u   cnt_wr_addr,
    input  bpc_pkg::plane_t      cnt_wr_data,
    output bpc_pkg::lane_state_t lane_state [bpc_pkg::LANES],
    output bpc_pkg::plane_t      top_plane
);

    // column held between coder clock strobes
    bpc_pkg::coeff_t coeff_held [bpc_pkg::LANES];

    stripe_capture u_capture (
        .clk_rc     (clk_rc),
        .rst        (rst),
        .clk_sg     (clk_sg),
        .stall_vld  (stall_vld),
        .coeff_in   (coeff_in),
        .coeff_held (coeff_held)
    );

    // all lanes see the same plane, so the plane can sweep under one column
    for (genvar g = 0; g < bpc_pkg::LANES; g++) begin : g_lane
        coeff_state_lane u_lane (
            .coeff     (coeff_held[g]),
            .bit_plane (bit_plane),
            .state     (lane_state[g])
        );
    end

    top_plane_table u_table (
        .clk_rc      (clk_rc),
        .rst         (rst),
        .cnt_wr_en   (cnt_wr_en),
        .cnt_wr_addr (cnt_wr_addr),
        .cnt_wr_data (cnt_wr_data),
        .sel         (sel),
        .top_plane   (top_plane)
    );

endmodule

//--- source/coeff_state_lane.sv
`timescale 1ns/1ps
module coeff_state_lane (
    input  bpc_pkg::coeff_t      coeff,
    input  bpc_pkg::plane_t      bit_plane,
    output bpc_pkg::lane_state_t state
);

    bpc_pkg::plane_t msb_pos;
    bpc_pkg::plane_t refine_limit;
    logic            coded_plane;
    logic            sigma_bit;
    logic            mag_bit;
    logic            gamma_bit;

    // leading one of the magnitude
    // ones below the lowest coded plane are ignored and read as 0
    always_comb begin
        msb_pos = '0;
        for (int i = bpc_pkg::MIN_CODED_PLANE; i < bpc_pkg::MAG_W; i++) begin
            if (coeff.mag[i]) begin
                msb_pos = bpc_pkg::plane_t'(i);
            end
        end
    end

    // already significant once the scan is below the leading one
    assign sigma_bit = (bit_plane < msb_pos);

    assign coded_plane = (bit_plane >= bpc_pkg::plane_t'(bpc_pkg::MIN_CODED_PLANE));

    always_comb begin
        if (coded_plane) begin
            mag_bit = coeff.mag[bit_plane];
        end else begin
            mag_bit = 1'b0;
        end
    end

    // first two planes under the leading one are not refinement yet
    assign refine_limit = msb_pos - bpc_pkg::plane_t'(2);

    always_comb begin
        if (msb_pos < bpc_pkg::plane_t'(bpc_pkg::GAMMA_MIN_MSB)) begin
            gamma_bit = 1'b0;
        end else if (bit_plane > refine_limit) begin
            gamma_bit = 1'b0;
        end else begin
            gamma_bit = 1'b1;
        end
    end

    always_comb begin
        state.sign  = coeff.sign;
        state.mag   = mag_bit;
        state.gamma = gamma_bit;
        state.sigma = sigma_bit;
    end

endmodule

//--- source/stripe_capture.sv
`timescale 1ns/1ps
module stripe_capture (
    input  logic            clk_rc,
    input  logic            rst,
    input  logic            clk_sg,
    input  logic            stall_vld,
    input  bpc_pkg::coeff_t coeff_in   [bpc_pkg::LANES],
    output bpc_pkg::coeff_t coeff_held [bpc_pkg::LANES]
);

    logic clk_sg_q;
    logic cap_strobe;
    logic load_en;

    // slow coder clock sampled as plain data in the clk_rc domain
    always_ff @(posedge clk_rc or negedge rst) begin
        if (!rst) begin
            clk_sg_q <= 1'b0;
        end else begin
            clk_sg_q <= clk_sg;
        end
    end

    // one clk_rc cycle wide, on the low to high step of clk_sg
    assign cap_strobe = clk_sg & ~clk_sg_q;

    // a stalled strobe is dropped, not deferred
    assign load_en = cap_strobe & ~stall_vld;

    always_ff @(posedge clk_rc or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < bpc_pkg::LANES; i++) begin
                coeff_held[i] <= '0;
            end
        end else if (load_en) begin
            for (int i = 0; i < bpc_pkg::LANES; i++) begin
                coeff_held[i] <= coeff_in[i];
            end
        end
    end

endmodule

//--- source/top_plane_table.sv
`timescale 1ns/1ps
module top_plane_table (
    input  logic               clk_rc,
    input  logic               rst,
    input  logic               cnt_wr_en,
    input  bpc_pkg::band_sel_u cnt_wr_addr,
    input  bpc_pkg::plane_t    cnt_wr_data,
    input  bpc_pkg::band_sel_u sel,
    output bpc_pkg::plane_t    top_plane
);

    // per-subband counts, one entry per flat selector value
    bpc_pkg::plane_t cnt_mem [bpc_pkg::TABLE_DEPTH];

    logic            comp_ok;
    logic            top_level;
    logic            detail_band;
    logic            sel_valid;
    bpc_pkg::plane_t cnt_rd;

    always_ff @(posedge clk_rc or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < bpc_pkg::TABLE_DEPTH; i++) begin
                cnt_mem[i] <= '0;
            end
        end else if (cnt_wr_en) begin
            cnt_mem[cnt_wr_addr.addr] <= cnt_wr_data;
        end
    end

    // Y, U, V only
    assign comp_ok = (sel.f.comp < bpc_pkg::COMP_W'(bpc_pkg::NUM_COMPS));

    // coarsest level takes all four bands including LL
    assign top_level = (sel.f.level == bpc_pkg::LEVEL_W'(bpc_pkg::TOP_LEVEL));

    // finer levels have no LL, band 0 is empty there
    assign detail_band = (sel.f.level < bpc_pkg::LEVEL_W'(bpc_pkg::TOP_LEVEL))
                       && (sel.f.band != '0);

    assign sel_valid = comp_ok && (top_level || detail_band);

    assign cnt_rd = cnt_mem[sel.addr];

    // sum wraps in four bits
    always_comb begin
        if (sel_valid) begin
            top_plane = cnt_rd + bpc_pkg::plane_t'(bpc_pkg::TOP_PLANE_OFFSET);
        end else begin
            top_plane = '0;
        end
    end

endmodule

//--- verif/bpc_state_gen_asserts.sv
`timescale 1ns/1ps
module bpc_state_gen_asserts (
    input logic               clk_rc,
    input logic               rst,
    input logic               clk_sg,
    input logic               stall_vld,
    input bpc_pkg::coeff_t    coeff_in   [bpc_pkg::LANES],
    input bpc_pkg::coeff_t    coeff_held [bpc_pkg::LANES],
    input bpc_pkg::band_sel_u sel,
    input bpc_pkg::plane_t    top_plane
);

    // failure counts, read by the testbench at the end of the run
    int load_fail_cnt = 0;
    int stall_fail_cnt = 0;
    int level_fail_cnt = 0;

    logic [bpc_pkg::LANES*bpc_pkg::COEFF_W-1:0] in_flat;
    logic [bpc_pkg::LANES*bpc_pkg::COEFF_W-1:0] held_flat;

    always_comb begin
        for (int i = 0; i < bpc_pkg::LANES; i++) begin
            in_flat[i*bpc_pkg::COEFF_W +: bpc_pkg::COEFF_W]   = coeff_in[i];
            held_flat[i*bpc_pkg::COEFF_W +: bpc_pkg::COEFF_W] = coeff_held[i];
        end
    end

    // strobe seen as clk_sg high after a low sample
    a_load: assert property (@(posedge clk_rc) disable iff (!rst)
        (clk_sg && !$past(clk_sg) && !stall_vld) |=> (held_flat == $past(in_flat)))
    else begin
        load_fail_cnt++;
        $error("held column differs from coeff_in after an unstalled strobe");
    end

    a_stall: assert property (@(posedge clk_rc) disable iff (!rst)
        (clk_sg && !$past(clk_sg) && stall_vld) |=> $stable(held_flat))
    else begin
        stall_fail_cnt++;
        $error("held column changed on a stalled strobe");
    end

    // levels above the coarsest do not exist
    a_level: assert property (@(posedge clk_rc) disable iff (!rst)
        (sel.f.level > bpc_pkg::LEVEL_W'(bpc_pkg::TOP_LEVEL)) |-> (top_plane == '0))
    else begin
        level_fail_cnt++;
        $error("top_plane nonzero for a level above the coarsest");
    end

endmodule

bind bpc_state_gen bpc_state_gen_asserts u_asserts (
    .clk_rc     (clk_rc),
    .rst        (rst),
    .clk_sg     (clk_sg),
    .stall_vld  (stall_vld),
    .coeff_in   (coeff_in),
    .coeff_held (coeff_held),
    .sel        (sel),
    .top_plane  (top_plane)
);

//--- verif/bpc_state_gen_tb.sv
`timescale 1ns/1ps
module bpc_state_gen_tb;

    localparam int SEED = 32'hcb3e;
    // all tests together run about 1500 cycles
    localparam int CYCLE_LIMIT = 5000;
    localparam int NUM_RANDOM = 40;
    localparam int NUM_PLANES = 16;

    logic                 clk_rc;
    logic                 rst;
    logic                 clk_sg;
    logic                 stall_vld;
    bpc_pkg::coeff_t      coeff_in   [bpc_pkg::LANES];
    bpc_pkg::plane_t      bit_plane;
    bpc_pkg::band_sel_u   sel;
    logic                 cnt_wr_en;
    bpc_pkg::band_sel_u   cnt_wr_addr;
    bpc_pkg::plane_t      cnt_wr_data;
    bpc_pkg::lane_state_t lane_state [bpc_pkg::LANES];
    bpc_pkg::plane_t      top_plane;

    // reference state: column the DUT should hold, and the count table
    bpc_pkg::coeff_t next_col [bpc_pkg::LANES];
    bpc_pkg::coeff_t exp_held [bpc_pkg::LANES];
    int              tbl_model [bpc_pkg::TABLE_DEPTH];

    int cycle_cnt = 0;
    int check_cnt = 0;
    int err_cnt = 0;
    int assert_err;

    bpc_state_gen dut_i (
        .clk_rc      (clk_rc),
        .rst         (rst),
        .clk_sg      (clk_sg),
        .stall_vld   (stall_vld),
        .coeff_in    (coeff_in),
        .bit_plane   (bit_plane),
        .sel         (sel),
        .cnt_wr_en   (cnt_wr_en),
        .cnt_wr_addr (cnt_wr_addr),
        .cnt_wr_data (cnt_wr_data),
        .lane_state  (lane_state),
        .top_plane   (top_plane)
    );

    initial clk_rc = 1'b0;
    always #5 clk_rc = ~clk_rc;

    always @(posedge clk_rc) begin
        cycle_cnt++;
        if (cycle_cnt == CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    // lane rule worked out on plain integers
    function automatic bpc_pkg::lane_state_t exp_state(input bpc_pkg::coeff_t c, input int p);
        int                   pos;
        bpc_pkg::lane_state_t s;
        pos = 0;
        for (int i = bpc_pkg::MAG_W - 1; i >= bpc_pkg::MIN_CODED_PLANE; i--) begin
            if (c.mag[i] && pos == 0) begin
                pos = i;
            end
        end
        s.sign  = c.sign;
        s.sigma = (p < pos);
        s.mag   = (p >= bpc_pkg::MIN_CODED_PLANE) ? c.mag[p] : 1'b0;
        s.gamma = (pos >= bpc_pkg::GAMMA_MIN_MSB) && (p <= pos - 2);
        return s;
    endfunction

    // address layout is level, comp, band from the top
    function automatic logic sel_is_valid(input int a);
        int lvl;
        int cmp;
        int bnd;
        lvl = a >> 4;
        cmp = (a >> 2) & 3;
        bnd = a & 3;
        if (cmp >= bpc_pkg::NUM_COMPS) begin
            return 1'b0;
        end
        return (lvl == bpc_pkg::TOP_LEVEL) || (lvl < bpc_pkg::TOP_LEVEL && bnd != 0);
    endfunction

    function automatic bpc_pkg::plane_t exp_top_plane(input int a);
        if (!sel_is_valid(a)) begin
            return '0;
        end
        return bpc_pkg::plane_t'((tbl_model[a] + bpc_pkg::TOP_PLANE_OFFSET) % 16);
    endfunction

    function automatic int count_pattern(input int a);
        return (a * 5 + (a >> 4)) % 16;
    endfunction

    task automatic check_state(input string name, input bpc_pkg::lane_state_t exp,
                               input bpc_pkg::lane_state_t act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_plane(input string name, input bpc_pkg::plane_t exp,
                               input bpc_pkg::plane_t act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic set_lane(input int l, input logic s, input logic [15:0] m);
        next_col[l].sign = s;
        next_col[l].mag  = m;
    endtask

    // clk_sg high for two cycles; the strobe edge is the second one
    task automatic capture_column(input logic stall);
        @(posedge clk_rc);
        for (int l = 0; l < bpc_pkg::LANES; l++) begin
            coeff_in[l] <= next_col[l];
        end
        stall_vld <= stall;
        clk_sg    <= 1'b1;
        @(posedge clk_rc);
        @(posedge clk_rc);
        clk_sg    <= 1'b0;
        stall_vld <= 1'b0;
        @(posedge clk_rc);
        if (!stall) begin
            for (int l = 0; l < bpc_pkg::LANES; l++) begin
                exp_held[l] = next_col[l];
            end
        end
    endtask

    task automatic sweep_planes(input string name);
        for (int p = 0; p < NUM_PLANES; p++) begin
            @(posedge clk_rc);
            bit_plane <= bpc_pkg::plane_t'(p);
            @(negedge clk_rc);
            for (int l = 0; l < bpc_pkg::LANES; l++) begin
                check_state($sformatf("%s lane %0d plane %0d", name, l, p),
                            exp_state(exp_held[l], p), lane_state[l]);
            end
        end
    endtask

    task automatic write_count(input int a, input int v);
        @(posedge clk_rc);
        cnt_wr_en        <= 1'b1;
        cnt_wr_addr.addr <= bpc_pkg::SEL_W'(a);
        cnt_wr_data      <= bpc_pkg::plane_t'(v);
        tbl_model[a] = v % 16;
    endtask

    task automatic stop_writes();
        @(posedge clk_rc);
        cnt_wr_en <= 1'b0;
    endtask

    task automatic read_all_selections(input string name);
        for (int a = 0; a < bpc_pkg::TABLE_DEPTH; a++) begin
            @(posedge clk_rc);
            sel.addr <= bpc_pkg::SEL_W'(a);
            @(negedge clk_rc);
            check_plane($sformatf("%s sel 0x%02h", name, a), exp_top_plane(a), top_plane);
        end
    endtask

    task automatic reset_values();
        sweep_planes("reset");
        read_all_selections("reset");
    endtask

    task automatic directed_states();
        set_lane(0, 1'b0, 16'h0000);
        set_lane(1, 1'b1, 16'h000f);
        set_lane(2, 1'b0, 16'h0040);
        set_lane(3, 1'b1, 16'h8001);
        capture_column(1'b0);
        sweep_planes("directed column 0");
        set_lane(0, 1'b1, 16'h7fff);
        set_lane(1, 1'b0, 16'h8001);
        set_lane(2, 1'b1, 16'h0040);
        set_lane(3, 1'b0, 16'h000f);
        capture_column(1'b0);
        sweep_planes("directed column 1");
        // leading one at 4, 5 and 7 around the gamma threshold
        set_lane(0, 1'b1, 16'h0000);
        set_lane(1, 1'b0, 16'h0010);
        set_lane(2, 1'b1, 16'h0020);
        set_lane(3, 1'b0, 16'h0080);
        capture_column(1'b0);
        sweep_planes("directed column 2");
    endtask

    task automatic stall_holds();
        set_lane(0, 1'b0, 16'h1234);
        set_lane(1, 1'b1, 16'h00f0);
        set_lane(2, 1'b0, 16'h4000);
        set_lane(3, 1'b1, 16'h0300);
        capture_column(1'b0);
        sweep_planes("stall before");
        set_lane(0, 1'b1, 16'h0808);
        set_lane(1, 1'b0, 16'h7000);
        set_lane(2, 1'b1, 16'h0005);
        set_lane(3, 1'b0, 16'hffff);
        capture_column(1'b1);
        sweep_planes("stall held");
        capture_column(1'b0);
        sweep_planes("stall released");
    endtask

    task automatic table_lookup();
        for (int a = 0; a < bpc_pkg::TABLE_DEPTH; a++) begin
            if (sel_is_valid(a)) begin
                write_count(a, count_pattern(a));
            end
        end
        stop_writes();
        read_all_selections("table lookup");
    endtask

    task automatic invalid_selects();
        for (int a = 0; a < bpc_pkg::TABLE_DEPTH; a++) begin
            if (!sel_is_valid(a)) begin
                write_count(a, count_pattern(a) ^ 9);
            end
        end
        stop_writes();
        read_all_selections("invalid selects");
    endtask

    task automatic random_columns();
        for (int n = 0; n < NUM_RANDOM; n++) begin
            for (int l = 0; l < bpc_pkg::LANES; l++) begin
                next_col[l].sign = 1'($urandom);
                // shift spreads the leading one over all planes
                next_col[l].mag  = 16'($urandom) >> ($urandom % 16);
            end
            capture_column(1'b0);
            sweep_planes($sformatf("random column %0d", n));
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst         = 1'b0;
        clk_sg      = 1'b0;
        stall_vld   = 1'b0;
        bit_plane   = '0;
        sel         = '0;
        cnt_wr_en   = 1'b0;
        cnt_wr_addr = '0;
        cnt_wr_data = '0;
        for (int l = 0; l < bpc_pkg::LANES; l++) begin
            coeff_in[l] = '0;
            next_col[l] = '0;
            exp_held[l] = '0;
        end
        for (int a = 0; a < bpc_pkg::TABLE_DEPTH; a++) begin
            tbl_model[a] = 0;
        end

        repeat (2) @(posedge clk_rc);
        rst <= 1'b1;

        reset_values();
        directed_states();
        stall_holds();
        table_lookup();
        invalid_selects();
        random_columns();

        assert_err = dut_i.u_asserts.load_fail_cnt + dut_i.u_asserts.stall_fail_cnt
                   + dut_i.u_asserts.level_fail_cnt;
        $display("checks %0d, value errors %0d, assertion errors %0d",
                 check_cnt, err_cnt, assert_err);
        if (err_cnt == 0 && assert_err == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
